//--- all.f
+incdir+hdl
hdl/hps_io_pkg.sv
hdl/audio_pkg.sv
hdl/aud_sample_filter.sv
hdl/hps_ctrl_regs.sv
hdl/aud_channel_mix.sv
hdl/sys_top.sv
tb/tb_clock.sv
tb/tb_sys_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_sys_top -Mdir obj_dir -o sim_tb_sys_top
./obj_dir/sim_tb_sys_top | tee sim.log

if grep -q "All tests passed!" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi

//--- tb/tb_sys_top.sv
// Control register and stereo mixer testbench
`default_nettype none

`include "sys_config.svh"

module tb_sys_top;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		audio_pkg::sample_t core_l;
		audio_pkg::sample_t core_r;
		audio_pkg::sample_t lin_l;
		audio_pkg::sample_t lin_r;
		logic               is_signed;
		audio_pkg::mix_t    mix;
		audio_pkg::att_t    att;
		audio_pkg::sample_t exp_l;
		audio_pkg::sample_t exp_r;
	} audio_row_t;

	localparam int SETTLE_CYCLES = 16;
	localparam int ROW_COUNT     = 16;

	wire                   clk_sys;
	wire                   resetd;
	logic                  io_uio;
	logic                  io_strobe;
	hps_io_pkg::io_word_t  io_din;
	logic                  led_user;
	logic [1:0]            led_power;
	logic                  led_disk;
	logic                  audio_signed;
	audio_pkg::mix_t       audio_mix;
	audio_pkg::sample_t    core_l;
	audio_pkg::sample_t    core_r;
	audio_pkg::sample_t    lin_l;
	audio_pkg::sample_t    lin_r;
	hps_io_pkg::led_word_t led;
	audio_pkg::sample_t    audio_l;
	audio_pkg::sample_t    audio_r;

	audio_row_t            audio_rows [ROW_COUNT];
	audio_row_t            glitch_row;
	hps_io_pkg::led_cfg_t  cur_cfg;
	audio_pkg::att_t       cur_att;
	logic [31:0]           rng_state;
	int                    test_errors;
	int                    tests_passed;
	int                    tests_failed;

	tb_clock clock_i (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	sys_top sys_top_i (
		.clk_sys         (clk_sys),
		.resetd          (resetd),
		.i_io_uio        (io_uio),
		.i_io_strobe     (io_strobe),
		.i_io_din        (io_din),
		.i_led_user      (led_user),
		.i_led_power     (led_power),
		.i_led_disk      (led_disk),
		.i_audio_signed  (audio_signed),
		.i_audio_mix     (audio_mix),
		.i_core_audio_l  (core_l),
		.i_core_audio_r  (core_r),
		.i_linux_audio_l (lin_l),
		.i_linux_audio_r (lin_r),
		.o_led           (led),
		.o_audio_l       (audio_l),
		.o_audio_r       (audio_r)
	);

	//////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic audio_pkg::sample_t next_sample();
		rng_state = xorshift32(rng_state);
		return rng_state[15:0];
	endfunction

	// Status pattern from the current inputs, overridden per bit
	function automatic hps_io_pkg::led_word_t expected_led(input hps_io_pkg::led_cfg_t cfg);
		hps_io_pkg::led_word_t status;
		hps_io_pkg::led_word_t result;
		status    = '0;
		status[0] = led_user;
		status[2] = led_disk;
		status[4] = led_power[1] ? led_power[0] : 1'b1;
		for (int b = 0; b < `LED_COUNT; b++) begin
			result[b] = cfg.led_overtake[b] ? cfg.led_state[b] : status[b];
		end
		return result;
	endfunction

	function automatic int channel_sum(input audio_pkg::sample_t core,
		input audio_pkg::sample_t lin, input logic is_signed);
		int conv;
		conv = is_signed ? int'($signed(core)) : int'(core >> 1);
		return conv + int'($signed(lin));
	endfunction

	function automatic audio_pkg::sample_t mixed_output(input int s, input int p,
		input audio_pkg::mix_t mix, input audio_pkg::att_t att);
		int v;
		case (mix)
			audio_pkg::MIX_25:   v = s - (s >>> 3) + (p >>> 2);
			audio_pkg::MIX_50:   v = s - (s >>> 2) + (p >>> 1);
			audio_pkg::MIX_MONO: v = (s >>> 1) + p;
			default:             v = s;
		endcase
		if (att[`ATT_MUTE_BIT]) v = 0;
		else v = v >>> att[`ATT_MUTE_BIT-1:0];
		if (v > 32767) v = 32767;
		else if (v < -32768) v = -32768;
		return v[15:0];
	endfunction

	// Both pre values come first, then each side mixes the other's
	function automatic audio_row_t make_row(input audio_pkg::sample_t c_l,
		input audio_pkg::sample_t c_r, input audio_pkg::sample_t l_l,
		input audio_pkg::sample_t l_r, input logic is_signed,
		input audio_pkg::mix_t mix, input audio_pkg::att_t att);
		audio_row_t row;
		int s_l;
		int s_r;
		s_l = channel_sum(c_l, l_l, is_signed);
		s_r = channel_sum(c_r, l_r, is_signed);
		row.core_l    = c_l;
		row.core_r    = c_r;
		row.lin_l     = l_l;
		row.lin_r     = l_r;
		row.is_signed = is_signed;
		row.mix       = mix;
		row.att       = att;
		row.exp_l     = mixed_output(s_l, s_r >>> 1, mix, att);
		row.exp_r     = mixed_output(s_r, s_l >>> 1, mix, att);
		return row;
	endfunction

	task automatic build_audio_table();
		audio_pkg::att_t shifts [4];
		shifts = '{5'd1, 5'd3, 5'd7, 5'h12};
		for (int i = 0; i < 8; i++) begin
			audio_rows[i] = make_row(next_sample(), next_sample(), next_sample(),
				next_sample(), i >= 4, audio_pkg::mix_t'(i[1:0]), 5'd0);
		end
		for (int i = 8; i < 12; i++) begin
			audio_rows[i] = make_row(next_sample(), next_sample(), next_sample(),
				next_sample(), i[0], audio_pkg::mix_t'(i[1:0]), shifts[i-8]);
		end
		// Full scale, all of these saturate
		audio_rows[12] = make_row(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 1'b1,
			audio_pkg::MIX_NONE, 5'd0);
		audio_rows[13] = make_row(16'h8000, 16'h8000, 16'h8000, 16'h8000, 1'b1,
			audio_pkg::MIX_NONE, 5'd0);
		audio_rows[14] = make_row(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 1'b1,
			audio_pkg::MIX_MONO, 5'd0);
		audio_rows[15] = make_row(16'hFFFF, 16'hFFFF, 16'h7FFF, 16'h7FFF, 1'b0,
			audio_pkg::MIX_50, 5'd0);
	endtask

	//////////////////////////////////////////////////////////////
	// Bus and check helpers
	//////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_word(input hps_io_pkg::io_word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		tick();
		io_strobe = 1'b0;
	endtask

	task automatic set_volume(input audio_pkg::att_t att);
		io_uio = 1'b1;
		tick();
		bus_word({8'h00, `CMD_VOLUME});
		bus_word({11'h000, att});
		io_uio = 1'b0;
		tick();
		cur_att = att;
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] want);
		assert (got == want) else begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, what, got, want);
			test_errors++;
		end
	endtask

	task automatic check_led(input string what);
		check_value(what, {8'h00, led}, {8'h00, expected_led(cur_cfg)});
	endtask

	task automatic run_audio_row(input audio_row_t row, input int idx);
		if (row.att != cur_att) set_volume(row.att);
		core_l       = row.core_l;
		core_r       = row.core_r;
		lin_l        = row.lin_l;
		lin_r        = row.lin_r;
		audio_signed = row.is_signed;
		audio_mix    = row.mix;
		repeat (SETTLE_CYCLES) tick();
		check_value($sformatf("o_audio_l row %0d", idx), audio_l, row.exp_l);
		check_value($sformatf("o_audio_r row %0d", idx), audio_r, row.exp_r);
	endtask

	task automatic start_test();
		test_errors = 0;
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, test_errors);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial begin
		int wait_cycles;
		io_uio       = 1'b0;
		io_strobe    = 1'b0;
		io_din       = '0;
		led_user     = 1'b0;
		led_power    = 2'b00;
		led_disk     = 1'b0;
		audio_signed = 1'b0;
		audio_mix    = audio_pkg::MIX_NONE;
		core_l       = '0;
		core_r       = '0;
		lin_l        = '0;
		lin_r        = '0;
		rng_state    = 32'd48017;
		cur_cfg      = '0;
		cur_att      = '0;
		tests_passed = 0;
		tests_failed = 0;
		build_audio_table();

		tick();
		wait_cycles = 0;
		while (resetd !== 1'b0 && wait_cycles < 20) begin
			tick();
			wait_cycles++;
		end

		if (resetd !== 1'b0) begin
			$display("Timeout: reset was never released");
			$display("Test failures found");
		end else begin
			// Status pattern only, and volume at its reset value
			start_test();
			for (int c = 0; c < 16; c++) begin
				led_user  = c[0];
				led_power = c[2:1];
				led_disk  = c[3];
				tick();
				check_led($sformatf("o_led status %0d", c));
			end
			run_audio_row(audio_rows[0], 0);
			finish_test("reset state");

			start_test();
			led_user  = 1'b1;
			led_power = 2'b10;
			led_disk  = 1'b1;
			io_uio    = 1'b1;
			tick();
			bus_word({8'h00, `CMD_LED});
			cur_cfg = 16'h3CA5;
			bus_word(cur_cfg);
			check_led("o_led after LED write");
			led_user = 1'b0;
			tick();
			check_led("o_led status passthrough");
			cur_cfg = 16'hFF5A;
			bus_word(cur_cfg);
			check_led("o_led after rewrite");
			io_uio = 1'b0;
			tick();
			finish_test("LED frame");

			start_test();
			bus_word({8'h00, `CMD_LED});
			bus_word(16'h0000);
			check_led("o_led words without select");
			io_uio = 1'b1;
			tick();
			bus_word(16'h0031);
			bus_word(16'h0000);
			check_led("o_led unknown command");
			io_uio = 1'b0;
			tick();
			io_uio = 1'b1;
			tick();
			bus_word({8'h00, `CMD_LED});
			cur_cfg = 16'h0F06;
			bus_word(cur_cfg);
			check_led("o_led new frame");
			io_uio = 1'b0;
			tick();
			finish_test("framing");

			start_test();
			for (int r = 0; r < ROW_COUNT; r++) begin
				run_audio_row(audio_rows[r], r);
			end
			finish_test("audio table");

			// One-cycle glitch on both core inputs
			start_test();
			glitch_row = make_row(next_sample(), next_sample(), next_sample(),
				next_sample(), 1'b1, audio_pkg::MIX_50, 5'd0);
			run_audio_row(glitch_row, ROW_COUNT);
			core_l = ~glitch_row.core_l;
			core_r = glitch_row.core_r ^ 16'h1234;
			tick();
			core_l = glitch_row.core_l;
			core_r = glitch_row.core_r;
			for (int c = 0; c < 12; c++) begin
				tick();
				check_value($sformatf("o_audio_l glitch cycle %0d", c), audio_l,
					glitch_row.exp_l);
				check_value($sformatf("o_audio_r glitch cycle %0d", c), audio_r,
					glitch_row.exp_r);
			end
			finish_test("glitch filter");

			$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
			if (tests_failed == 0) begin
				$display("All tests passed!");
			end else begin
				$display("Test failures found");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// Testbench clock and reset
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic resetd
);

	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Held for three rising edges, released just after the third
	initial begin
		resetd = 1'b1;
		repeat (3) @(posedge clk_sys);
		#1 resetd = 1'b0;
	end

endmodule

`default_nettype wire

//--- hdl/sys_top.sv
// Control registers and stereo mixer top
`default_nettype none

module sys_top (
	input  wire                   clk_sys,
	input  wire                   resetd,

	input  wire                   i_io_uio,
	input  wire                   i_io_strobe,
	input  hps_io_pkg::io_word_t  i_io_din,

	input  wire                   i_led_user,
	input  wire  [1:0]            i_led_power,
	input  wire                   i_led_disk,

	input  wire                   i_audio_signed,
	input  audio_pkg::mix_t       i_audio_mix,
	input  audio_pkg::sample_t    i_core_audio_l,
	input  audio_pkg::sample_t    i_core_audio_r,
	input  audio_pkg::sample_t    i_linux_audio_l,
	input  audio_pkg::sample_t    i_linux_audio_r,

	output hps_io_pkg::led_word_t o_led,
	output audio_pkg::sample_t    o_audio_l,
	output audio_pkg::sample_t    o_audio_r
);

	audio_pkg::att_t        vol_att;
	audio_pkg::audio_ctrl_t audio_ctrl;
	audio_pkg::sample_t     pre_l;
	audio_pkg::sample_t     pre_r;

	hps_ctrl_regs hps_ctrl_regs_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.i_led_user  (i_led_user),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.o_led       (o_led),
		.o_att       (vol_att)
	);

	// Volume from software, format and mix from the core
	assign audio_ctrl.att       = vol_att;
	assign audio_ctrl.mix       = i_audio_mix;
	assign audio_ctrl.is_signed = i_audio_signed;

	////////////////////////////////////////////////////////////
	// Left and right channels, pre signals crossed
	////////////////////////////////////////////////////////////

	aud_channel_mix mix_l_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_ctrl        (audio_ctrl),
		.i_core_audio  (i_core_audio_l),
		.i_linux_audio (i_linux_audio_l),
		.i_pre_in      (pre_r),
		.o_pre_out     (pre_l),
		.o_audio       (o_audio_l)
	);

	aud_channel_mix mix_r_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_ctrl        (audio_ctrl),
		.i_core_audio  (i_core_audio_r),
		.i_linux_audio (i_linux_audio_r),
		.i_pre_in      (pre_l),
		.o_pre_out     (pre_r),
		.o_audio       (o_audio_r)
	);

endmodule

`default_nettype wire

//--- hdl/aud_channel_mix.sv
// Audio channel mixer pipeline
`default_nettype none

`include "sys_config.svh"

module aud_channel_mix (
	input  wire                    clk_sys,
	input  wire                    resetd,
	input  audio_pkg::audio_ctrl_t i_ctrl,
	input  audio_pkg::sample_t     i_core_audio,
	input  audio_pkg::sample_t     i_linux_audio,
	input  audio_pkg::sample_t     i_pre_in,
	output audio_pkg::sample_t     o_pre_out,
	output audio_pkg::sample_t     o_audio
);

	audio_pkg::sample_t      core_filt;
	audio_pkg::wide_sample_t conv_d;
	audio_pkg::wide_sample_t conv_q;
	audio_pkg::wide_sample_t sum_q;
	audio_pkg::wide_sample_t mix_d;
	audio_pkg::wide_sample_t mix_q;
	audio_pkg::wide_sample_t att_q;

	// Arithmetic shifts of the sum and of the other channel's pre value
	audio_pkg::wide_sample_t sum_div2;
	audio_pkg::wide_sample_t sum_div4;
	audio_pkg::wide_sample_t sum_div8;
	audio_pkg::wide_sample_t pre_ext;
	audio_pkg::wide_sample_t pre_div2;
	audio_pkg::wide_sample_t pre_div4;

	aud_sample_filter filter_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_sample (i_core_audio),
		.o_sample (core_filt)
	);

	// Unsigned core audio is halved into the positive range
	assign conv_d = i_ctrl.is_signed ? {core_filt[`SAMPLE_WIDTH-1], core_filt} :
		{2'b00, core_filt[`SAMPLE_WIDTH-1:1]};

	assign o_pre_out = sum_q[`SAMPLE_WIDTH:1];

	assign sum_div2 = $signed(sum_q) >>> 1;
	assign sum_div4 = $signed(sum_q) >>> 2;
	assign sum_div8 = $signed(sum_q) >>> 3;
	assign pre_ext  = {i_pre_in[`SAMPLE_WIDTH-1], i_pre_in};
	assign pre_div2 = $signed(pre_ext) >>> 1;
	assign pre_div4 = $signed(pre_ext) >>> 2;

	////////////////////////////////////////////////////////////
	// Stereo cross-mix
	////////////////////////////////////////////////////////////

	always_comb begin
		mix_d = sum_q;
		case (i_ctrl.mix)
			audio_pkg::MIX_NONE: mix_d = sum_q;
			audio_pkg::MIX_25:   mix_d = sum_q - sum_div8 + pre_div4;
			audio_pkg::MIX_50:   mix_d = sum_q - sum_div4 + pre_div2;
			audio_pkg::MIX_MONO: mix_d = sum_div2 + pre_ext;
			default:             mix_d = sum_q;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			conv_q <= '0;
			sum_q  <= '0;
			mix_q  <= '0;
			att_q  <= '0;
		end else begin
			conv_q <= conv_d;
			sum_q  <= conv_q + {i_linux_audio[`SAMPLE_WIDTH-1], i_linux_audio};
			mix_q  <= mix_d;
			if (i_ctrl.att[`ATT_MUTE_BIT]) begin
				att_q <= '0;
			end else begin
				att_q <= $signed(mix_q) >>> i_ctrl.att[`ATT_MUTE_BIT-1:0];
			end
		end
	end

	// Clamp to the 16-bit signed range
	assign o_audio = (att_q[`SAMPLE_WIDTH] ^ att_q[`SAMPLE_WIDTH-1]) ?
		{att_q[`SAMPLE_WIDTH], {(`SAMPLE_WIDTH-1){att_q[`SAMPLE_WIDTH-1]}}} :
		att_q[`SAMPLE_WIDTH-1:0];

endmodule

`default_nettype wire

//--- hdl/hps_ctrl_regs.sv
// HPS command decoder and board LEDs
`default_nettype none

`include "sys_config.svh"

module hps_ctrl_regs (
	input  wire                   clk_sys,
	input  wire                   resetd,

	input  wire                   i_io_uio,
	input  wire                   i_io_strobe,
	input  hps_io_pkg::io_word_t  i_io_din,

	input  wire                   i_led_user,
	input  wire  [1:0]            i_led_power,
	input  wire                   i_led_disk,

	output hps_io_pkg::led_word_t o_led,
	output audio_pkg::att_t       o_att
);

	hps_io_pkg::frame_state_t frame_state;
	hps_io_pkg::cmd_t         cmd;
	hps_io_pkg::led_cfg_t     led_cfg;
	audio_pkg::att_t          att;
	hps_io_pkg::led_word_t    led_status;
	logic                     led_power;

	////////////////////////////////////////////////////////////
	// Command frame decoder
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			frame_state <= hps_io_pkg::FRAME_IDLE;
			cmd         <= '0;
			led_cfg     <= '0;
			att         <= '0;
		end else if (!i_io_uio) begin
			// Select dropped, next word starts a new frame
			frame_state <= hps_io_pkg::FRAME_IDLE;
		end else if (i_io_strobe) begin
			case (frame_state)
				hps_io_pkg::FRAME_IDLE: begin
					cmd         <= i_io_din[`CMD_WIDTH-1:0];
					frame_state <= hps_io_pkg::FRAME_DATA;
				end
				hps_io_pkg::FRAME_DATA: begin
					// Every data word rewrites the target register
					if (cmd == `CMD_LED) begin
						led_cfg <= hps_io_pkg::led_cfg_t'(i_io_din);
					end
					if (cmd == `CMD_VOLUME) begin
						att <= i_io_din[`ATT_MUTE_BIT:0];
					end
				end
				default: begin
					frame_state <= hps_io_pkg::FRAME_IDLE;
				end
			endcase
		end
	end

	assign o_att = att;

	////////////////////////////////////////////////////////////
	// Board LED panel
	////////////////////////////////////////////////////////////

	// Power LED is lit unless the core takes control of it
	assign led_power = i_led_power[1] ? i_led_power[0] : 1'b1;

	always_comb begin
		led_status    = '0;
		led_status[0] = i_led_user;
		led_status[2] = i_led_disk;
		led_status[4] = led_power;
	end

	// Overridden bits show software state, the rest show status
	assign o_led = (led_cfg.led_overtake & led_cfg.led_state) |
		(~led_cfg.led_overtake & led_status);

endmodule

`default_nettype wire

//--- hdl/aud_sample_filter.sv
// Core sample glitch filter
`default_nettype none

module aud_sample_filter (
	input  wire                clk_sys,
	input  wire                resetd,
	input  audio_pkg::sample_t i_sample,
	output audio_pkg::sample_t o_sample
);

	audio_pkg::sample_t dly_1;
	audio_pkg::sample_t dly_2;
	audio_pkg::sample_t dly_3;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			dly_1    <= '0;
			dly_2    <= '0;
			dly_3    <= '0;
			o_sample <= '0;
		end else begin
			dly_1 <= i_sample;
			dly_2 <= dly_1;
			dly_3 <= dly_2;
			// Load only once the value has held for two taps
			if (dly_2 == dly_3) begin
				o_sample <= dly_2;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/audio_pkg.sv
// Audio mixer types
`default_nettype none

`include "sys_config.svh"

package audio_pkg;

	// Two's-complement sample
	typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

	// One extra bit of headroom for sums
	typedef logic [`SAMPLE_WIDTH:0] wide_sample_t;

	// Mute bit on top, right-shift count below
	typedef logic [`ATT_MUTE_BIT:0] att_t;

	// Stereo cross-mix amount
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_t;

	// Controls common to both channels
	typedef struct packed {
		att_t att;
		mix_t mix;
		logic is_signed;
	} audio_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/hps_io_pkg.sv
// HPS control bus types
`default_nettype none

`include "sys_config.svh"

package hps_io_pkg;

	// One word on the HPS bus
	typedef logic [`IO_WIDTH-1:0] io_word_t;

	// Command code from the low part of the first word
	typedef logic [`CMD_WIDTH-1:0] cmd_t;

	// One bit per board LED
	typedef logic [`LED_COUNT-1:0] led_word_t;

	// Same layout as the LED command data word
	typedef struct packed {
		led_word_t led_overtake;
		led_word_t led_state;
	} led_cfg_t;

	// Command frame decoder states
	typedef enum logic {
		FRAME_IDLE,
		FRAME_DATA
	} frame_state_t;

endpackage

`default_nettype wire

//--- hdl/sys_config.svh
// System configuration constants
`ifndef SYS_CONFIG_SVH
`define SYS_CONFIG_SVH

// HPS word bus
`define IO_WIDTH     16
`define CMD_WIDTH    8

// Command codes carried in the first word of a frame
`define CMD_LED      8'h25
`define CMD_VOLUME   8'h26

// Board LED panel
`define LED_COUNT    8

// Audio sample format
`define SAMPLE_WIDTH 16

// Top attenuation bit mutes, the bits below it are a shift count
`define ATT_MUTE_BIT 4

`endif
